/* all.f */
hdl/i2c_bus_pkg.sv
hdl/reg_map_pkg.sv
hdl/i2c_line_sampler.sv
hdl/i2c_target_fsm.sv
hdl/i2c_reg_bank.sv
hdl/i2c_target_top.sv
test/tb_clock_gen.sv
test/i2c_target_tb.sv

/* run.sh */
#!/bin/sh
# build and run the I2C target testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f all.f --top-module i2c_target_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vi2c_target_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test failed" "$LOG"; then
    exit 1
fi
if ! grep -q "Test completed successfully" "$LOG"; then
    echo "simulation ended without a result"
    exit 1
fi
exit 0

/* test/i2c_target_tb.sv */
`timescale 1ns/1ps

module i2c_target_tb;

    localparam logic [6:0] SLAVE_ADDR = 7'h2A;
    localparam int         REG_DEPTH  = 16;
    localparam int         MAX_BURST  = 6;
    localparam int         WR_ITERS   = 5;
    // start and stop of one transfer count as three bus bits
    localparam int TOTAL_BYTES = 2 + WR_ITERS * (2 * MAX_BURST + 5) + (6 + REG_DEPTH) + 9 + 10;
    localparam int TRANSFERS   = 1 + 3 * WR_ITERS + 9;
    localparam int WATCHDOG_CYCLES = (TOTAL_BYTES * 9 + TRANSFERS * 3) * 20 * 2;

    logic               CLK;
    logic               RST_n;
    logic               scl;
    logic               sda_m;     // master side of the line
    logic               sda_line;  // resolved open-drain level
    logic               sda_drive_low;
    logic               busy;
    logic [31:0]        lfsr_state;
    reg_map_pkg::byte_t model_regs[$];
    reg_map_pkg::byte_t burst[$];
    int                 model_ptr;
    int                 errors;
    int                 tests;
    int                 passed;
    int                 err_mark;
    string              cur_test;

    assign sda_line = sda_m & ~sda_drive_low;

    tb_clock_gen clk_gen_i (.CLK(CLK), .RST_n(RST_n));

    i2c_target_top #(
        .SLAVE_ADDR (SLAVE_ADDR),
        .REG_DEPTH  (REG_DEPTH)
    ) dut_i (
        .CLK           (CLK),
        .RST_n         (RST_n),
        .scl           (scl),
        .sda_in        (sda_line),
        .sda_drive_low (sda_drive_low),
        .busy          (busy)
    );

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        repeat (n)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    task automatic report_mismatch(input string what, input logic [7:0] exp_v,
                                   input logic [7:0] act_v);
        $display("FAILED %s %s: expected %02h, actual %02h", cur_test, what, exp_v, act_v);
        errors++;
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge CLK);
    endtask

    task automatic begin_test(input string name);
        cur_test = name;
        err_mark = errors;
    endtask

    task automatic end_test();
        tests++;
        if (errors == err_mark)
        begin
            passed++;
            $display("PASS %s", cur_test);
        end
        else
            $display("FAIL %s, %0d mismatches", cur_test, errors - err_mark);
    endtask

    task automatic bus_start();
        wait_cycles(10);
        sda_m = 1'b0;  // sda falls with scl high
        wait_cycles(10);
        scl = 1'b0;
    endtask

    task automatic bus_stop();
        wait_cycles(5);
        sda_m = 1'b0;
        wait_cycles(5);
        scl = 1'b1;
        wait_cycles(10);
        sda_m = 1'b1;  // sda rises with scl high
        wait_cycles(10);
        if (busy !== 1'b0) report_mismatch("busy after stop", 8'h00, 8'(busy));
    endtask

    // one scl period with data set mid low phase and the line sampled mid high
    task automatic clock_bit(input logic b, output logic s);
        wait_cycles(5);
        sda_m = b;
        wait_cycles(5);
        scl = 1'b1;
        wait_cycles(5);
        s = sda_line;
        wait_cycles(5);
        scl = 1'b0;
    endtask

    task automatic send_byte(input logic [7:0] b, output logic nack);
        logic [7:0] sh;
        logic       s;
        sh = b;
        repeat (8)
        begin
            clock_bit(sh[7], s);
            sh = {sh[6:0], 1'b0};
        end
        if (busy !== 1'b1) report_mismatch("busy in byte", 8'h01, 8'(busy));
        clock_bit(1'b1, nack);  // released for the target ack
    endtask

    task automatic receive_byte(input logic nack, output logic [7:0] b);
        logic s;
        b = '0;
        repeat (8)
        begin
            clock_bit(1'b1, s);
            b = {b[6:0], s};
        end
        if (busy !== 1'b1) report_mismatch("busy in byte", 8'h01, 8'(busy));
        clock_bit(nack, s);
    endtask

    task automatic write_burst(input logic [7:0] p);
        logic nack;
        bus_start();
        send_byte({SLAVE_ADDR, 1'b0}, nack);
        if (nack !== 1'b0) report_mismatch("write cmd ack", 8'h00, 8'(nack));
        send_byte(p, nack);
        if (nack !== 1'b0) report_mismatch("pointer ack", 8'h00, 8'(nack));
        model_ptr = int'(p) % REG_DEPTH;
        foreach (burst[i])
        begin
            send_byte(burst[i], nack);
            if (nack !== 1'b0)
                report_mismatch("data ack", 8'h00, 8'(nack));
            else
                model_regs[model_ptr] = burst[i];
            model_ptr = (model_ptr + 1) % REG_DEPTH;
        end
        bus_stop();
    endtask

    task automatic set_pointer(input logic [7:0] p);
        burst.delete();
        write_burst(p);  // pointer byte only
    endtask

    task automatic read_burst(input int n, input logic release_check);
        logic               nack;
        logic               s;
        reg_map_pkg::byte_t got;
        reg_map_pkg::byte_t exp_b;
        bus_start();
        send_byte({SLAVE_ADDR, 1'b1}, nack);
        if (nack !== 1'b0) report_mismatch("read cmd ack", 8'h00, 8'(nack));
        for (int i = 0; i < n; i++)
        begin
            receive_byte(i == n - 1, got);  // nack on the last byte
            exp_b = model_regs[(model_ptr + i) % REG_DEPTH];
            if (got !== exp_b) report_mismatch($sformatf("read byte %0d", i), exp_b, got);
        end
        model_ptr = (model_ptr + n - 1) % REG_DEPTH;  // nack does not advance
        if (release_check)
        begin
            repeat (9)
            begin
                clock_bit(1'b1, s);
                if (sda_drive_low !== 1'b0)
                    report_mismatch("drive after nack", 8'h00, 8'(sda_drive_low));
            end
        end
        bus_stop();
    endtask

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge CLK);
        $display("timeout, the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Test failed");
        $finish;
    end

    initial
    begin
        logic [31:0] v;
        logic [7:0]  p;
        logic [6:0]  bad;
        logic        nack;
        int          n;
        scl        = 1'b1;
        sda_m      = 1'b1;
        lfsr_state = 32'h1024;
        errors     = 0;
        tests      = 0;
        passed     = 0;
        model_ptr  = 0;
        for (int i = 0; i < REG_DEPTH; i++)
            model_regs.push_back(8'h00);
        @(posedge RST_n);
        wait_cycles(4);

        begin_test("reset_state");
        if (busy !== 1'b0) report_mismatch("busy after reset", 8'h00, 8'(busy));
        if (sda_drive_low !== 1'b0)
            report_mismatch("drive after reset", 8'h00, 8'(sda_drive_low));
        read_burst(1, 1'b0);
        end_test();

        begin_test("write_read_burst");
        for (int it = 0; it < WR_ITERS; it++)
        begin
            draw_bits(8, v);
            p = v[7:0];
            draw_bits(3, v);
            n = int'(v[2:0]) % MAX_BURST + 1;
            if (it == WR_ITERS - 1)
            begin
                p = 8'(REG_DEPTH - 2);  // forces the wrap to 0
                n = 4;
            end
            burst.delete();
            repeat (n)
            begin
                draw_bits(8, v);
                burst.push_back(v[7:0]);
            end
            write_burst(p);
            set_pointer(p);
            read_burst(n, 1'b0);
        end
        end_test();

        begin_test("wrong_address");
        draw_bits(7, v);
        bad = v[6:0];
        if (bad == SLAVE_ADDR)
            bad = bad ^ 7'h01;
        bus_start();
        send_byte({bad, 1'b0}, nack);
        if (nack !== 1'b1) report_mismatch("foreign cmd nack", 8'h01, 8'(nack));
        repeat (2)
        begin
            draw_bits(8, v);
            send_byte(v[7:0], nack);
            if (nack !== 1'b1) report_mismatch("ignored byte nack", 8'h01, 8'(nack));
        end
        bus_stop();
        set_pointer(8'h00);
        read_burst(REG_DEPTH, 1'b0);
        end_test();

        begin_test("busy_flag");
        if (busy !== 1'b0) report_mismatch("busy when idle", 8'h00, 8'(busy));
        burst.delete();
        repeat (2)
        begin
            draw_bits(8, v);
            burst.push_back(v[7:0]);
        end
        draw_bits(8, v);
        p = v[7:0];
        write_burst(p);
        set_pointer(p);
        read_burst(2, 1'b0);
        end_test();

        begin_test("read_nack");
        draw_bits(8, v);
        set_pointer(v[7:0]);
        read_burst(3, 1'b1);
        read_burst(2, 1'b0);  // continues at the held pointer
        end_test();

        $display("tests %0d, passed %0d, errors %0d", tests, passed, errors);
        if (errors == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

/* test/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen
#(
    parameter int HALF_NS      = 2,  // 4 ns period
    parameter int RESET_CYCLES = 5
)
(
    output logic CLK,
    output logic RST_n
);

    initial
    begin
        CLK = 1'b0;
        forever #(HALF_NS) CLK = ~CLK;
    end

    initial
    begin
        RST_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge CLK);
        @(negedge CLK);  // release away from the active edge
        RST_n = 1'b1;
    end

endmodule

/* hdl/i2c_target_top.sv */
`timescale 1ns/1ps

module i2c_target_top
#(
    parameter logic [i2c_bus_pkg::ADDR_W-1:0] SLAVE_ADDR = 7'h2A,
    parameter int                             REG_DEPTH  = 16
)
(
    input  logic CLK,
    input  logic RST_n,
    input  logic scl,
    input  logic sda_in,
    output logic sda_drive_low,
    output logic busy
);

    i2c_bus_pkg::bus_events_t events;
    reg_map_pkg::reg_write_t  wr;
    reg_map_pkg::byte_t       rd_addr;
    reg_map_pkg::byte_t       rd_data;

    i2c_line_sampler sampler_i
    (
        .CLK    (CLK),
        .RST_n  (RST_n),
        .scl    (scl),
        .sda_in (sda_in),
        .events (events)
    );

    i2c_target_fsm #(
        .SLAVE_ADDR (SLAVE_ADDR),
        .REG_DEPTH  (REG_DEPTH)
    ) fsm_i (
        .CLK           (CLK),
        .RST_n         (RST_n),
        .events        (events),
        .rd_data       (rd_data),
        .wr            (wr),
        .rd_addr       (rd_addr),
        .sda_drive_low (sda_drive_low),
        .busy          (busy)
    );

    i2c_reg_bank #(
        .REG_DEPTH (REG_DEPTH)
    ) regs_i (
        .CLK     (CLK),
        .RST_n   (RST_n),
        .wr      (wr),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

endmodule

/* hdl/i2c_reg_bank.sv */
`timescale 1ns/1ps

module i2c_reg_bank
#(
    parameter int REG_DEPTH = 16
)
(
    input  logic                    CLK,
    input  logic                    RST_n,
    input  reg_map_pkg::reg_write_t wr,
    input  reg_map_pkg::byte_t      rd_addr,
    output reg_map_pkg::byte_t      rd_data
);

    localparam int AW = (REG_DEPTH > 1) ? $clog2(REG_DEPTH) : 1;  // index bits

    reg_map_pkg::byte_t mem [REG_DEPTH];

    always_ff @(posedge CLK or negedge RST_n)
    begin
        if (!RST_n)
        begin
            for (int i = 0; i < REG_DEPTH; i++)
                mem[i] <= '0;
        end
        else if (wr.valid)
            mem[wr.addr[AW-1:0]] <= wr.data;
    end

    assign rd_data = mem[rd_addr[AW-1:0]];  // same-cycle read

    // pointer wrap upstream keeps reads inside the array
    a_rd_range : assert property (@(posedge CLK) disable iff (!RST_n)
        int'(rd_addr) < REG_DEPTH)
        else $error("read address beyond register bank");

endmodule

/* hdl/i2c_target_fsm.sv */
`timescale 1ns/1ps

module i2c_target_fsm
#(
    parameter logic [i2c_bus_pkg::ADDR_W-1:0] SLAVE_ADDR = 7'h2A,
    parameter int                             REG_DEPTH  = 16
)
(
    input  logic                     CLK,
    input  logic                     RST_n,
    input  i2c_bus_pkg::bus_events_t events,
    input  reg_map_pkg::byte_t       rd_data,
    output reg_map_pkg::reg_write_t  wr,
    output reg_map_pkg::byte_t       rd_addr,
    output logic                     sda_drive_low,
    output logic                     busy
);

    i2c_bus_pkg::proto_state_t state;
    i2c_bus_pkg::proto_state_t nx_state;
    logic [3:0]                bit_cnt;     // bits seen in current byte
    logic [3:0]                nx_bit_cnt;
    reg_map_pkg::byte_t        ptr;         // register pointer
    reg_map_pkg::byte_t        nx_ptr;
    logic                      nx_drive;
    logic                      nx_busy;
    reg_map_pkg::byte_t        shift_in;
    reg_map_pkg::byte_t        nx_shift_in;
    logic [6:0]                shift_out;   // msb already on the line
    logic [6:0]                nx_shift_out;
    logic                      rw;          // 1 = master reads
    logic                      nx_rw;
    reg_map_pkg::byte_t        rx_byte;

    function automatic reg_map_pkg::byte_t ptr_inc(input reg_map_pkg::byte_t p);
        if (int'(p) >= REG_DEPTH - 1)
            return '0;
        return p + 8'd1;
    endfunction

    function automatic reg_map_pkg::byte_t ptr_wrap(input reg_map_pkg::byte_t b);
        int tmp;
        tmp = int'(b) % REG_DEPTH;
        return reg_map_pkg::byte_t'(tmp);
    endfunction

    assign rx_byte = {shift_in[6:0], events.sda};  // byte including current bit
    assign rd_addr = ptr;

    always_comb
    begin
        nx_state     = state;
        nx_bit_cnt   = bit_cnt;
        nx_ptr       = ptr;
        nx_drive     = sda_drive_low;
        nx_busy      = busy;
        nx_shift_in  = shift_in;
        nx_shift_out = shift_out;
        nx_rw        = rw;
        wr           = '0;

        case (state)
            i2c_bus_pkg::CMD, i2c_bus_pkg::PTR, i2c_bus_pkg::WDATA:
            begin
                if (events.scl_rise)
                begin
                    nx_shift_in = rx_byte;
                    nx_bit_cnt  = bit_cnt + 4'd1;
                    if (state == i2c_bus_pkg::WDATA && bit_cnt == 4'd7)
                    begin
                        wr.valid = 1'b1;  // store on the 8th bit
                        wr.addr  = ptr;
                        wr.data  = rx_byte;
                        nx_ptr   = ptr_inc(ptr);
                    end
                end
                else if (events.scl_fall && bit_cnt == 4'd8)
                begin
                    nx_bit_cnt = '0;
                    nx_drive   = 1'b1;  // ack by default
                    if (state == i2c_bus_pkg::CMD)
                    begin
                        nx_rw = shift_in[0];
                        if (shift_in[7:1] == SLAVE_ADDR)
                            nx_state = i2c_bus_pkg::CMD_ACK;
                        else
                        begin
                            nx_state = i2c_bus_pkg::IGNORE;
                            nx_drive = 1'b0;  // leave sda released, nack
                        end
                    end
                    else if (state == i2c_bus_pkg::PTR)
                    begin
                        nx_ptr   = ptr_wrap(shift_in);
                        nx_state = i2c_bus_pkg::PTR_ACK;
                    end
                    else
                        nx_state = i2c_bus_pkg::WDATA_ACK;
                end
            end
            i2c_bus_pkg::CMD_ACK:
            begin
                if (events.scl_fall)
                begin
                    if (rw)
                    begin
                        nx_shift_out = rd_data[6:0];
                        nx_drive     = ~rd_data[7];
                        nx_state     = i2c_bus_pkg::RDATA;
                    end
                    else
                    begin
                        nx_drive = 1'b0;
                        nx_state = i2c_bus_pkg::PTR;
                    end
                end
            end
            i2c_bus_pkg::PTR_ACK, i2c_bus_pkg::WDATA_ACK:
            begin
                if (events.scl_fall)
                begin
                    nx_drive = 1'b0;
                    nx_state = i2c_bus_pkg::WDATA;
                end
            end
            i2c_bus_pkg::RDATA:
            begin
                if (events.scl_rise)
                    nx_bit_cnt = bit_cnt + 4'd1;
                else if (events.scl_fall)
                begin
                    if (bit_cnt == 4'd8)
                    begin
                        nx_bit_cnt = '0;
                        nx_drive   = 1'b0;  // release for master ack
                        nx_state   = i2c_bus_pkg::MSTR_ACK;
                    end
                    else
                    begin
                        nx_drive     = ~shift_out[6];
                        nx_shift_out = {shift_out[5:0], 1'b0};
                    end
                end
            end
            i2c_bus_pkg::MSTR_ACK:
            begin
                if (events.scl_rise)
                begin
                    if (events.sda)
                        nx_state = i2c_bus_pkg::IGNORE;  // nack ends the read
                    else
                        nx_ptr = ptr_inc(ptr);
                end
                else if (events.scl_fall)
                begin
                    nx_shift_out = rd_data[6:0];  // next register, pointer already moved
                    nx_drive     = ~rd_data[7];
                    nx_state     = i2c_bus_pkg::RDATA;
                end
            end
            default: ;  // idle and ignore wait for bus conditions
        endcase

        // bus conditions win over anything in progress
        if (events.stop_det)
        begin
            nx_state   = i2c_bus_pkg::IDLE;
            nx_bit_cnt = '0;
            nx_drive   = 1'b0;
            nx_busy    = 1'b0;
            wr         = '0;
        end
        else if (events.start_det)
        begin
            nx_state   = i2c_bus_pkg::CMD;
            nx_bit_cnt = '0;
            nx_drive   = 1'b0;
            nx_busy    = 1'b1;
            wr         = '0;
        end
    end

    always_ff @(posedge CLK or negedge RST_n)
    begin
        if (!RST_n)
        begin
            state         <= i2c_bus_pkg::IDLE;
            bit_cnt       <= '0;
            ptr           <= '0;
            sda_drive_low <= 1'b0;
            busy          <= 1'b0;
        end
        else
        begin
            state         <= nx_state;
            bit_cnt       <= nx_bit_cnt;
            ptr           <= nx_ptr;
            sda_drive_low <= nx_drive;
            busy          <= nx_busy;
        end
    end

    always_ff @(posedge CLK)
    begin
        shift_in  <= nx_shift_in;
        shift_out <= nx_shift_out;
        rw        <= nx_rw;
    end

    a_sda_timing : assert property (@(posedge CLK) disable iff (!RST_n)
        $changed(sda_drive_low) |->
            $past(events.scl_fall | events.start_det | events.stop_det))
        else $error("sda drive changed outside the scl low phase");

    a_wr_range : assert property (@(posedge CLK) disable iff (!RST_n)
        wr.valid |-> int'(wr.addr) < REG_DEPTH)
        else $error("write address beyond register bank");

endmodule

/* hdl/i2c_line_sampler.sv */
`timescale 1ns/1ps

module i2c_line_sampler
(
    input  logic                     CLK,
    input  logic                     RST_n,
    input  logic                     scl,
    input  logic                     sda_in,
    output i2c_bus_pkg::bus_events_t events
);

    logic scl_meta;
    logic scl_sync;
    logic scl_hist;
    logic sda_meta;
    logic sda_sync;
    logic sda_hist;

    // bus idles high, so all stages reset to 1
    always_ff @(posedge CLK or negedge RST_n)
    begin
        if (!RST_n)
        begin
            scl_meta <= 1'b1;
            scl_sync <= 1'b1;
            scl_hist <= 1'b1;
            sda_meta <= 1'b1;
            sda_sync <= 1'b1;
            sda_hist <= 1'b1;
        end
        else
        begin
            scl_meta <= scl;
            scl_sync <= scl_meta;
            scl_hist <= scl_sync;  // previous sample for edge compare
            sda_meta <= sda_in;
            sda_sync <= sda_meta;
            sda_hist <= sda_sync;
        end
    end

    always_comb
    begin
        events.scl       = scl_sync;
        events.sda       = sda_sync;
        events.scl_rise  = scl_sync & ~scl_hist;
        events.scl_fall  = ~scl_sync & scl_hist;
        // scl held high across both samples
        events.start_det = scl_sync & scl_hist & sda_hist & ~sda_sync;
        events.stop_det  = scl_sync & scl_hist & ~sda_hist & sda_sync;
    end

    a_sda_stable_at_edge : assert property (@(posedge CLK) disable iff (!RST_n)
        (events.scl_rise || events.scl_fall) |-> $stable(events.sda))
        else $error("sda moved in the same cycle as an scl edge");

endmodule

/* hdl/reg_map_pkg.sv */
package reg_map_pkg;

    typedef logic [7:0] byte_t;  // one register

    // write port into the register bank
    typedef struct packed {
        logic  valid;  // single-cycle request
        byte_t addr;
        byte_t data;
    } reg_write_t;

endpackage

/* hdl/i2c_bus_pkg.sv */
package i2c_bus_pkg;

    localparam int ADDR_W = 7;  // 7-bit target addressing

    // one cycle worth of sampled bus activity
    typedef struct packed {
        logic scl;        // synchronized clock level
        logic sda;        // synchronized data level
        logic scl_rise;   // single-cycle strobe
        logic scl_fall;   // single-cycle strobe
        logic start_det;  // sda falls while scl high
        logic stop_det;   // sda rises while scl high
    } bus_events_t;

    typedef enum logic [3:0] {
        IDLE      = 4'd0,
        CMD       = 4'd1,  // address and r/w bit
        CMD_ACK   = 4'd2,
        PTR       = 4'd3,  // register pointer byte
        PTR_ACK   = 4'd4,
        WDATA     = 4'd5,
        WDATA_ACK = 4'd6,
        RDATA     = 4'd7,  // target shifts a byte out
        MSTR_ACK  = 4'd8,  // master acks or nacks
        IGNORE    = 4'd9   // not addressed, wait for stop
    } proto_state_t;

endpackage
